/* src/rob_pkg.sv */
package rob_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;
    localparam int TAG_W     = 4;   // room for up to 16 entries

    typedef logic [4:0]       reg_idx_t;
    typedef logic [TAG_W-1:0] rob_tag_t;

    typedef struct packed {
        logic     valid;
        logic     is_branch;
        reg_idx_t dest;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } decoded_inst_t;

    // branch view of a result word, predicted not taken
    typedef struct packed {
        logic        taken;
        logic [30:0] target;   // carried along only
    } branch_outcome_t;

    typedef union packed {
        logic [XLEN-1:0] data;
        branch_outcome_t branch;
    } cdb_result_u;

    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        cdb_result_u result;
    } cdb_t;

    // value is good when ready, otherwise tag names the producer
    typedef struct packed {
        logic            ready;
        rob_tag_t        tag;
        logic [XLEN-1:0] value;
        logic            pad;
    } operand_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        operand_t src1;
        operand_t src2;
    } issue_t;

    typedef struct packed {
        logic            valid;
        reg_idx_t        dest;
        logic [XLEN-1:0] value;
    } retire_t;

    typedef struct packed {
        logic            complete;
        logic [XLEN-1:0] value;
    } rob_read_t;

endpackage

/* src/map_table.sv */
`timescale 1ns/1ps

module map_table import rob_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     rename_en,
    input  reg_idx_t rename_dest,
    input  rob_tag_t rename_tag,
    input  retire_t  retire_in,
    input  rob_tag_t retire_tag,
    input  logic     squash,
    output rob_tag_t tag1,
    output rob_tag_t tag2,
    output logic     pend1,
    output logic     pend2
);

    logic [REG_COUNT-1:0] pending;
    rob_tag_t             tags [REG_COUNT];

    logic do_rename;
    logic do_clear;

    // r0 is never renamed, so it never shows up as pending
    assign do_rename = rename_en && (rename_dest != '0);

    // only drop the mapping if no younger producer took the register
    assign do_clear = retire_in.valid && pending[retire_in.dest] &&
                      (tags[retire_in.dest] == retire_tag);

    assign tag1  = tags[rs1];
    assign tag2  = tags[rs2];
    assign pend1 = pending[rs1];
    assign pend2 = pending[rs2];

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            pending <= '0;   // whole table forgotten on mispredict
        end else begin
            if (do_clear) begin
                pending[retire_in.dest] <= 1'b0;
            end
            if (do_rename) begin   // later write wins over the clear
                pending[rename_dest] <= 1'b1;
            end
        end
    end

    // tag field only means something while pending is set
    always_ff @(posedge clock) begin
        if (do_rename) begin
            tags[rename_dest] <= rename_tag;
        end
    end

endmodule

/* src/dispatch_stage.sv */
`timescale 1ns/1ps

module dispatch_stage import rob_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  decoded_inst_t   id_in,
    input  cdb_t            cdb_in,
    input  rob_tag_t        tail_tag,
    input  logic            rob_full,
    input  logic            stall,
    input  logic            squash,
    input  rob_tag_t        map_tag1,
    input  rob_tag_t        map_tag2,
    input  logic            map_pend1,
    input  logic            map_pend2,
    input  rob_read_t       rob_rd1,
    input  rob_read_t       rob_rd2,
    input  logic [XLEN-1:0] reg_val1,
    input  logic [XLEN-1:0] reg_val2,
    output logic            accept,
    output issue_t          issue_out
);

    operand_t src1;
    operand_t src2;

    // register file, then rob entry, then cdb bypass, else wait on tag
    function automatic operand_t resolve(
        input logic            pend,
        input rob_tag_t        tag,
        input rob_read_t       rd,
        input logic [XLEN-1:0] reg_val,
        input cdb_t            cdb
    );
        operand_t op;
        op.ready = 1'b1;
        op.tag   = tag;
        op.value = reg_val;
        op.pad   = 1'b0;
        if (pend) begin
            if (rd.complete) begin
                op.value = rd.value;
            end else if (cdb.valid && (cdb.tag == tag)) begin
                op.value = cdb.result.data;   // same cycle broadcast
            end else begin
                op.ready = 1'b0;
                op.value = '0;
            end
        end
        return op;
    endfunction

    assign accept = id_in.valid && !rob_full && !stall && !squash;

    assign src1 = resolve(map_pend1, map_tag1, rob_rd1, reg_val1, cdb_in);
    assign src2 = resolve(map_pend2, map_tag2, rob_rd2, reg_val2, cdb_in);

    always_ff @(posedge clock) begin
        if (reset) begin
            issue_out.valid <= 1'b0;
        end else begin
            issue_out.valid <= accept;   // one cycle pulse per dispatch
            if (accept) begin
                issue_out.tag  <= tail_tag;
                issue_out.src1 <= src1;
                issue_out.src2 <= src2;
            end
        end
    end

endmodule

/* src/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer import rob_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          alloc,
    input  decoded_inst_t alloc_inst,
    input  cdb_t          cdb_in,
    input  logic          stall,
    input  rob_tag_t      rd_tag1,
    input  rob_tag_t      rd_tag2,
    output rob_read_t     rd1,
    output rob_read_t     rd2,
    output rob_tag_t      tail_tag,
    output rob_tag_t      head_tag,
    output logic          rob_full,
    output retire_t       retire_out,
    output logic          squash
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    typedef struct packed {
        logic            busy;
        logic            complete;
        logic            mispredict;
        logic            is_branch;
        reg_idx_t        dest;
        logic [XLEN-1:0] value;
    } rob_entry_t;

    rob_entry_t entries [ROB_DEPTH];

    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [IDX_W:0]   count;

    rob_entry_t       head_entry;
    logic [IDX_W-1:0] cdb_idx;
    logic [IDX_W-1:0] rd_idx1;
    logic [IDX_W-1:0] rd_idx2;
    logic             retire_go;

    assign tail_tag = rob_tag_t'(tail);
    assign head_tag = rob_tag_t'(head);
    assign rob_full = (count == (IDX_W+1)'(ROB_DEPTH));

    assign cdb_idx = cdb_in.tag[IDX_W-1:0];
    assign rd_idx1 = rd_tag1[IDX_W-1:0];
    assign rd_idx2 = rd_tag2[IDX_W-1:0];

    // operand lookups for dispatch
    assign rd1.complete = entries[rd_idx1].busy && entries[rd_idx1].complete;
    assign rd1.value    = entries[rd_idx1].value;
    assign rd2.complete = entries[rd_idx2].busy && entries[rd_idx2].complete;
    assign rd2.value    = entries[rd_idx2].value;

    assign head_entry = entries[head];
    assign retire_go  = head_entry.busy && head_entry.complete && !stall;

    // taken branch at the head flushes everything younger
    assign squash = retire_go && head_entry.mispredict;

    // branches and r0 never write a register
    assign retire_out.valid = retire_go && !head_entry.is_branch &&
                              (head_entry.dest != '0);
    assign retire_out.dest  = head_entry.dest;
    assign retire_out.value = head_entry.value;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].busy       <= 1'b0;
                entries[i].complete   <= 1'b0;
                entries[i].mispredict <= 1'b0;
            end
        end else begin
            if (cdb_in.valid) begin   // recorded even while stalled
                entries[cdb_idx].complete <= 1'b1;
                entries[cdb_idx].value    <= cdb_in.result.data;
                if (entries[cdb_idx].is_branch && cdb_in.result.branch.taken) begin
                    entries[cdb_idx].mispredict <= 1'b1;
                end
            end
            if (alloc) begin
                entries[tail].busy       <= 1'b1;
                entries[tail].complete   <= 1'b0;
                entries[tail].mispredict <= 1'b0;
                entries[tail].is_branch  <= alloc_inst.is_branch;
                entries[tail].dest       <= alloc_inst.dest;
                tail <= tail + 1'b1;   // wraps, depth is a power of two
            end
            if (retire_go) begin
                entries[head].busy <= 1'b0;
                head <= head + 1'b1;
            end
            case ({alloc, retire_go})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;   // both or neither
            endcase
        end
    end

endmodule

/* src/arch_reg_file.sv */
`timescale 1ns/1ps

module arch_reg_file import rob_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  retire_t         retire_in,
    input  reg_idx_t        rd_idx1,
    input  reg_idx_t        rd_idx2,
    output logic [XLEN-1:0] rd_val1,
    output logic [XLEN-1:0] rd_val2
);

    logic [XLEN-1:0] regs [REG_COUNT];

    logic wr_en;

    assign wr_en = retire_in.valid && (retire_in.dest != '0);

    // old value is seen in the write cycle
    // map table still points at the rob entry then
    assign rd_val1 = (rd_idx1 == '0) ? '0 : regs[rd_idx1];
    assign rd_val2 = (rd_idx2 == '0) ? '0 : regs[rd_idx2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[retire_in.dest] <= retire_in.value;   // committed state
        end
    end

endmodule

/* src/rob_core.sv */
`timescale 1ns/1ps

module rob_core import rob_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          stall,
    input  decoded_inst_t id_in,
    input  cdb_t          cdb_in,
    output issue_t        issue_out,
    output retire_t       retire_out,
    output logic          rob_full,
    output logic          squash
);

    logic            accept;
    rob_tag_t        tail_tag;
    rob_tag_t        head_tag;
    rob_tag_t        map_tag1;
    rob_tag_t        map_tag2;
    logic            map_pend1;
    logic            map_pend2;
    rob_read_t       rob_rd1;
    rob_read_t       rob_rd2;
    logic [XLEN-1:0] reg_val1;
    logic [XLEN-1:0] reg_val2;

    dispatch_stage u_dispatch (
        .clock     (clock),
        .reset     (reset),
        .id_in     (id_in),
        .cdb_in    (cdb_in),
        .tail_tag  (tail_tag),
        .rob_full  (rob_full),
        .stall     (stall),
        .squash    (squash),
        .map_tag1  (map_tag1),
        .map_tag2  (map_tag2),
        .map_pend1 (map_pend1),
        .map_pend2 (map_pend2),
        .rob_rd1   (rob_rd1),
        .rob_rd2   (rob_rd2),
        .reg_val1  (reg_val1),
        .reg_val2  (reg_val2),
        .accept    (accept),
        .issue_out (issue_out)
    );

    map_table u_map (
        .clock       (clock),
        .reset       (reset),
        .rs1         (id_in.rs1),
        .rs2         (id_in.rs2),
        .rename_en   (accept),
        .rename_dest (id_in.dest),
        .rename_tag  (tail_tag),
        .retire_in   (retire_out),
        .retire_tag  (head_tag),
        .squash      (squash),
        .tag1        (map_tag1),
        .tag2        (map_tag2),
        .pend1       (map_pend1),
        .pend2       (map_pend2)
    );

    // pending tags from the map go straight to the rob lookup ports
    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clock      (clock),
        .reset      (reset),
        .alloc      (accept),
        .alloc_inst (id_in),
        .cdb_in     (cdb_in),
        .stall      (stall),
        .rd_tag1    (map_tag1),
        .rd_tag2    (map_tag2),
        .rd1        (rob_rd1),
        .rd2        (rob_rd2),
        .tail_tag   (tail_tag),
        .head_tag   (head_tag),
        .rob_full   (rob_full),
        .retire_out (retire_out),
        .squash     (squash)
    );

    arch_reg_file u_regs (
        .clock     (clock),
        .reset     (reset),
        .retire_in (retire_out),
        .rd_idx1   (id_in.rs1),
        .rd_idx2   (id_in.rs2),
        .rd_val1   (reg_val1),
        .rd_val2   (reg_val2)
    );

endmodule

/* test/rob_core_assert.sv */
`timescale 1ns/1ps

module rob_core_assert import rob_pkg::*; (
    input logic          clock,
    input logic          reset,
    input logic          stall,
    input decoded_inst_t id_in,
    input issue_t        issue_out,
    input retire_t       retire_out,
    input logic          rob_full,
    input logic          squash
);

    logic dispatch_ok;

    assign dispatch_ok = id_in.valid && !rob_full && !stall && !squash;

    // r0 and branches never show up on the retire port
    a_retire_dest: assert property (@(posedge clock) disable iff (reset)
        retire_out.valid |-> (retire_out.dest != '0))
        else $error("retire_out.valid with dest 0");

    a_squash_empties: assert property (@(posedge clock) disable iff (reset)
        squash |=> !rob_full)
        else $error("rob_full high after squash");

    a_issue_source: assert property (@(posedge clock) disable iff (reset)
        issue_out.valid |-> $past(dispatch_ok))
        else $error("issue_out.valid without an accepted dispatch");

    a_issue_follows: assert property (@(posedge clock) disable iff (reset)
        dispatch_ok |=> issue_out.valid)
        else $error("accepted dispatch gave no issue packet");

endmodule

bind rob_core rob_core_assert u_assert (
    .clock      (clock),
    .reset      (reset),
    .stall      (stall),
    .id_in      (id_in),
    .issue_out  (issue_out),
    .retire_out (retire_out),
    .rob_full   (rob_full),
    .squash     (squash)
);

/* test/rob_core_tb.sv */
`timescale 1ns/1ps

module rob_core_tb import rob_pkg::*; ();

    localparam int DEPTH       = 8;
    localparam int RETIRE_WAIT = 16;
    // reset plus about 150 test cycles with 2x margin
    localparam int CYCLE_LIMIT = 2 * (8 + 150);

    logic          clock;
    logic          reset;
    logic          stall;
    decoded_inst_t id_in;
    cdb_t          cdb_in;
    issue_t        issue_out;
    retire_t       retire_out;
    logic          rob_full;
    logic          squash;

    logic [XLEN-1:0] model_regs [REG_COUNT];   // committed register model
    reg_idx_t        dest_of [16];
    logic [XLEN-1:0] value_of [16];
    rob_tag_t        next_tag;
    logic [15:0]     lfsr_state;
    int              check_count;
    int              error_count;
    int              cycle_count;

    rob_core #(
        .ROB_DEPTH (DEPTH)
    ) u_dut (
        .clock      (clock),
        .reset      (reset),
        .stall      (stall),
        .id_in      (id_in),
        .cdb_in     (cdb_in),
        .issue_out  (issue_out),
        .retire_out (retire_out),
        .rob_full   (rob_full),
        .squash     (squash)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] random_word();
        logic [31:0] word;
        logic        out_bit;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) lfsr_state = lfsr_state ^ 16'hB400;
            word = {word[30:0], out_bit};
        end
        return word;
    endfunction

    function automatic decoded_inst_t make_inst(input logic br, input reg_idx_t dest,
                                                input reg_idx_t rs1, input reg_idx_t rs2);
        decoded_inst_t inst;
        inst.valid     = 1'b1;
        inst.is_branch = br;
        inst.dest      = dest;
        inst.rs1       = rs1;
        inst.rs2       = rs2;
        return inst;
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_operand(input string what, input operand_t op,
                                 input logic exp_ready, input logic [31:0] exp_word);
        compare({what, " ready"}, op.ready, exp_ready);
        if (exp_ready) begin
            compare({what, " value"}, op.value, exp_word);
        end else begin
            compare({what, " tag"}, op.tag, exp_word);   // producer tag
        end
    endtask

    // inputs change 2 ns after the edge and outputs are read at the falling edge
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic dispatch_one(input decoded_inst_t inst, input cdb_t cdb,
                                input logic expect_issue, output issue_t iss);
        next_cycle();
        id_in  = inst;
        cdb_in = cdb;
        next_cycle();
        id_in  = '0;
        cdb_in = '0;
        @(negedge clock);
        iss = issue_out;
        compare("issue valid", issue_out.valid, expect_issue);
        if (expect_issue) begin
            compare("issue tag", iss.tag, next_tag);
            dest_of[next_tag] = inst.dest;
            next_tag = rob_tag_t'((next_tag + 1) % DEPTH);
        end
    endtask

    task automatic broadcast(input cdb_t c);
        next_cycle();
        cdb_in = c;
        next_cycle();
        cdb_in = '0;
        @(negedge clock);
    endtask

    task automatic complete_tag(input rob_tag_t tag, input logic [31:0] data);
        cdb_t c;
        c             = '0;
        c.valid       = 1'b1;
        c.tag         = tag;
        c.result.data = data;
        value_of[tag] = data;
        broadcast(c);
    endtask

    task automatic expect_retire(input rob_tag_t tag);
        int waited;
        waited = 0;
        while (!retire_out.valid && waited < RETIRE_WAIT) begin
            next_cycle();
            @(negedge clock);
            waited++;
        end
        if (!retire_out.valid) begin
            error_count++;
            $display("Error at %0t: tag %0d never retired", $time, tag);
        end else begin
            compare("retire dest", retire_out.dest, dest_of[tag]);
            compare("retire value", retire_out.value, value_of[tag]);
            model_regs[dest_of[tag]] = value_of[tag];
        end
        next_cycle();   // let this retire take effect
        @(negedge clock);
    endtask

    task automatic fill_rob();
        issue_t iss;
        for (int i = 0; i < DEPTH; i++) begin
            dispatch_one(make_inst(1'b0, reg_idx_t'(i + 1), 5'd0, 5'd0), '0, 1'b1, iss);
            compare("rob_full", rob_full, (i == DEPTH - 1));
        end
        dispatch_one(make_inst(1'b0, 5'd9, 5'd0, 5'd0), '0, 1'b0, iss);   // ninth is refused
        compare("rob_full held", rob_full, 1'b1);
    endtask

    task automatic retire_in_order();
        for (int t = DEPTH - 1; t >= 0; t--) begin
            complete_tag(rob_tag_t'(t), random_word());
            if (t > 0) compare("retire before head done", retire_out.valid, 1'b0);
        end
        for (int t = 0; t < DEPTH; t++) expect_retire(rob_tag_t'(t));
    endtask

    task automatic resolve_operands();
        issue_t      iss;
        cdb_t        c;
        rob_tag_t    t_block;
        rob_tag_t    t_prod;
        rob_tag_t    t_use;
        logic [31:0] prod_val;
        t_block = next_tag;   // stays incomplete so the producer cannot retire
        dispatch_one(make_inst(1'b0, 5'd12, 5'd0, 5'd0), '0, 1'b1, iss);
        t_prod = next_tag;
        dispatch_one(make_inst(1'b0, 5'd10, 5'd0, 5'd0), '0, 1'b1, iss);
        dispatch_one(make_inst(1'b0, 5'd14, 5'd10, 5'd1), '0, 1'b1, iss);
        check_operand("pending src1", iss.src1, 1'b0, 32'(t_prod));
        check_operand("committed src2", iss.src2, 1'b1, model_regs[1]);
        prod_val = random_word();
        complete_tag(t_prod, prod_val);
        dispatch_one(make_inst(1'b0, 5'd15, 5'd10, 5'd0), '0, 1'b1, iss);
        check_operand("rob src1", iss.src1, 1'b1, prod_val);
        t_use = next_tag;
        dispatch_one(make_inst(1'b0, 5'd13, 5'd0, 5'd0), '0, 1'b1, iss);
        c             = '0;   // result on the cdb in the dependent's dispatch cycle
        c.valid       = 1'b1;
        c.tag         = t_use;
        c.result.data = random_word();
        value_of[t_use] = c.result.data;
        dispatch_one(make_inst(1'b0, 5'd16, 5'd13, 5'd0), c, 1'b1, iss);
        check_operand("bypass src1", iss.src1, 1'b1, c.result.data);
        for (int k = 2; k < 6; k++) begin
            if (k != 4) complete_tag(rob_tag_t'((t_block + k) % DEPTH), random_word());
        end
        complete_tag(t_block, random_word());
        for (int k = 0; k < 6; k++) expect_retire(rob_tag_t'((t_block + k) % DEPTH));
        t_use = next_tag;
        dispatch_one(make_inst(1'b0, 5'd17, 5'd10, 5'd13), '0, 1'b1, iss);
        check_operand("retired src1", iss.src1, 1'b1, model_regs[10]);
        check_operand("retired src2", iss.src2, 1'b1, model_regs[13]);
        complete_tag(t_use, random_word());
        expect_retire(t_use);
    endtask

    task automatic guard_zero_register();
        issue_t   iss;
        rob_tag_t t_zero;
        rob_tag_t t_next;
        t_zero = next_tag;
        dispatch_one(make_inst(1'b0, 5'd0, 5'd0, 5'd0), '0, 1'b1, iss);
        t_next = next_tag;
        dispatch_one(make_inst(1'b0, 5'd18, 5'd0, 5'd0), '0, 1'b1, iss);
        complete_tag(t_zero, random_word() | 32'h1);   // nonzero data aimed at r0
        compare("retire valid for r0", retire_out.valid, 1'b0);
        complete_tag(t_next, random_word());
        expect_retire(t_next);
        t_next = next_tag;
        dispatch_one(make_inst(1'b0, 5'd19, 5'd0, 5'd18), '0, 1'b1, iss);
        check_operand("r0 src1", iss.src1, 1'b1, 32'h0);
        check_operand("r18 src2", iss.src2, 1'b1, model_regs[18]);
        complete_tag(t_next, random_word());
        expect_retire(t_next);
    endtask

    task automatic flush_on_mispredict();
        issue_t   iss;
        cdb_t     c;
        rob_tag_t t_branch;
        rob_tag_t t_young;
        t_branch = next_tag;
        // nonzero dest so only the branch rule keeps it off the retire port
        dispatch_one(make_inst(1'b1, 5'd25, 5'd0, 5'd0), '0, 1'b1, iss);
        t_young = next_tag;
        dispatch_one(make_inst(1'b0, 5'd20, 5'd0, 5'd0), '0, 1'b1, iss);
        dispatch_one(make_inst(1'b0, 5'd21, 5'd20, 5'd0), '0, 1'b1, iss);
        complete_tag(t_young, random_word());   // done but younger than the branch
        c                      = '0;
        c.valid                = 1'b1;
        c.tag                  = t_branch;
        c.result.branch.taken  = 1'b1;
        c.result.branch.target = 31'h100;
        broadcast(c);
        compare("squash at branch retire", squash, 1'b1);
        compare("retire valid at branch", retire_out.valid, 1'b0);
        next_tag = '0;
        repeat (3) begin
            next_cycle();
            @(negedge clock);
            compare("squash after flush", squash, 1'b0);
            compare("retire after flush", retire_out.valid, 1'b0);
            compare("rob_full after flush", rob_full, 1'b0);
        end
        t_young = next_tag;
        dispatch_one(make_inst(1'b0, 5'd22, 5'd20, 5'd10), '0, 1'b1, iss);
        check_operand("post squash src1", iss.src1, 1'b1, model_regs[20]);
        check_operand("post squash src2", iss.src2, 1'b1, model_regs[10]);
        complete_tag(t_young, random_word());
        expect_retire(t_young);
    endtask

    task automatic hold_on_stall();
        issue_t   iss;
        rob_tag_t t_held;
        t_held = next_tag;
        dispatch_one(make_inst(1'b0, 5'd23, 5'd0, 5'd0), '0, 1'b1, iss);
        next_cycle();
        stall = 1'b1;
        @(negedge clock);
        complete_tag(t_held, random_word());   // completion still recorded
        compare("retire while stalled", retire_out.valid, 1'b0);
        dispatch_one(make_inst(1'b0, 5'd24, 5'd0, 5'd0), '0, 1'b0, iss);
        repeat (2) begin
            next_cycle();
            @(negedge clock);
            compare("retire while stalled", retire_out.valid, 1'b0);
            compare("issue while stalled", issue_out.valid, 1'b0);
        end
        next_cycle();
        stall = 1'b0;
        @(negedge clock);
        compare("retire when stall falls", retire_out.valid, 1'b1);
        expect_retire(t_held);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        stall       = 1'b0;
        id_in       = '0;
        cdb_in      = '0;
        next_tag    = '0;
        lfsr_state  = 16'd62;
        check_count = 0;
        error_count = 0;
        for (int r = 0; r < REG_COUNT; r++) model_regs[r] = '0;
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;
        @(negedge clock);
        compare("rob_full after reset", rob_full, 1'b0);
        compare("squash after reset", squash, 1'b0);
        compare("issue after reset", issue_out.valid, 1'b0);
        compare("retire after reset", retire_out.valid, 1'b0);
        fill_rob();
        retire_in_order();
        resolve_operands();
        guard_zero_register();
        flush_on_mispredict();
        hold_on_stall();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* rob_core.f */
src/rob_pkg.sv
src/map_table.sv
src/dispatch_stage.sv
src/reorder_buffer.sv
src/arch_reg_file.sv
src/rob_core.sv
test/rob_core_assert.sv
test/rob_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module rob_core_tb \
    -f rob_core.f -o rob_core_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rob_core_sim > sim.log 2>&1
cat sim.log
grep -q "^Simulation completed successfully$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
